/* files.f */
source/cabinet_pkg.sv
source/input_sync.sv
source/key_decoder.sv
source/control_mapper.sv
source/audio_dac.sv
source/cabinet_io_top.sv
verification/cabinet_io_chk.sv
verification/cabinet_io_tb.sv

/* Makefile */
# Verilator simulation of the cabinet I/O testbench
VERILATOR ?= verilator
TOP       ?= cabinet_io_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/cabinet_io_tb.sv */
//====================
// Testbench for the cabinet control and sound path
// Random stimulus from $urandom, seeded once
// Control outputs are compared once they hold still for a few cycles
//====================

`timescale 1ns/1ps

module cabinet_io_tb import cabinet_pkg::*; ();

	localparam logic kind_controls = 1'b0;
	localparam logic kind_audio    = 1'b1;
	localparam int   stable_needed = 6;     // Longer than the 4-cycle key path
	localparam int   settle_limit  = 40;
	localparam int   audio_settle  = 16;
	localparam int   audio_window  = 2048;
	localparam int   ack_limit     = 4000;  // Covers one full audio window

	// Scan codes in model bit order, up first
	localparam logic [9:0][7:0] key_codes = {
		key_fire3, key_fire2, key_fire1, key_start2, key_start1,
		key_coin, key_right, key_left, key_down, key_up
	};

	logic                 clk_24;
	logic                 arst_n;
	key_event_t           key_event;
	joy_t                 joy_0;
	joy_t                 joy_1;
	logic                 rotate;
	logic [snd_width-1:0] snd_a;
	logic [snd_width-1:0] snd_b;
	logic [ctl_width-1:0] p1_controls;
	logic [ctl_width-1:0] p2_controls;
	logic                 bomb;
	logic                 audio_out;

	// Model state
	logic [9:0] btn_model;     // up, down, left, right, coin, start1, start2, fire1..3
	logic [7:0] joy0_model;
	logic [7:0] joy1_model;
	logic       rot_model;
	logic       strobe_state;

	// Request and acknowledge towards the comparing process
	logic        check_req;
	logic        check_ack;
	logic        check_kind;
	logic [15:0] check_expect;
	string       check_name;

	int checks;
	int errors;
	int timeouts;

	cabinet_io_top uut (
		.clk_24      (clk_24),
		.arst_n      (arst_n),
		.key_event   (key_event),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.rotate      (rotate),
		.snd_a       (snd_a),
		.snd_b       (snd_b),
		.p1_controls (p1_controls),
		.p2_controls (p2_controls),
		.bomb        (bomb),
		.audio_out   (audio_out)
	);

	always #10 clk_24 = ~clk_24;

	// ====================
	// Reference model
	// ====================
	function automatic logic [15:0] expected_controls(input logic [9:0] btn,
			input logic [7:0] j0, input logic [7:0] j1, input logic rot);
		logic any_up, any_down, any_left, any_right;
		logic up, down, left, right, fire, bmb;
		any_up    = btn[0] | j0[3] | j1[3];
		any_down  = btn[1] | j0[2] | j1[2];
		any_left  = btn[2] | j0[1] | j1[1];
		any_right = btn[3] | j0[0] | j1[0];
		if (rot) begin
			{up, down, left, right} = {any_up, any_down, any_left, any_right};
		end else begin
			{up, down, left, right} = {any_right, any_left, any_up, any_down};  // Quarter turn
		end
		fire = btn[7] | j0[4] | j1[4];
		bmb  = btn[8] | j0[5] | j1[5];
		return {1'b0, btn[4], btn[5], fire, up, down, left, right,
			1'b0, btn[6], fire, up, down, left, right, bmb};
	endfunction

	function automatic logic [15:0] expected_ones(input logic [7:0] a, input logic [7:0] b);
		return 16'(b) * 16'd4 + 16'(a);
	endfunction

	function automatic logic [9:0] press_model(input logic [9:0] btn, input logic [7:0] code,
			input logic pressed);
		logic [9:0] next;
		next = btn;
		for (int i = 0; i < 10; i++) begin
			if (code == key_codes[4'(i)]) next[4'(i)] = pressed;
		end
		return next;
	endfunction

	function automatic logic is_mapped(input logic [7:0] code);
		logic found;
		found = 1'b0;
		for (int i = 0; i < 10; i++) begin
			if (code == key_codes[4'(i)]) found = 1'b1;
		end
		return found;
	endfunction

	// ====================
	// Stimulus tasks
	// ====================
	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_24);
		strobe_state = ~strobe_state;
		key_event <= {strobe_state, pressed, 1'($urandom), code};  // Extended flag random
		btn_model = press_model(btn_model, code, pressed);
		repeat (2) @(posedge clk_24);
	endtask

	task automatic drive_levels(input logic [7:0] j0, input logic [7:0] j1, input logic rot);
		@(posedge clk_24);
		joy_0 <= j0;
		joy_1 <= j1;
		rotate <= rot;
		joy0_model = j0;
		joy1_model = j1;
		rot_model = rot;
	endtask

	task automatic drive_sound(input logic [7:0] a, input logic [7:0] b);
		@(posedge clk_24);
		snd_a <= a;
		snd_b <= b;
	endtask

	task automatic run_check(input string name, input logic kind, input logic [15:0] expected);
		int waited;
		check_name = name;
		check_kind = kind;
		check_expect = expected;
		check_req = 1'b1;
		waited = 0;
		while (!check_ack && waited < ack_limit) begin
			@(posedge clk_24);
			waited++;
		end
		if (!check_ack) begin
			timeouts++;
			$display("Timeout: comparing process never finished check %s", name);
		end
		check_req = 1'b0;
		waited = 0;
		while (check_ack && waited < ack_limit) begin
			@(posedge clk_24);
			waited++;
		end
		if (check_ack) begin
			timeouts++;
			$display("Timeout: comparing process never released check %s", name);
		end
	endtask

	// ====================
	// Comparing process
	// ====================
	initial begin : compare_outputs
		logic [15:0] actual;
		logic [15:0] previous;
		int          stable;
		int          waited;
		int          ones;
		int          n;
		check_ack = 1'b0;
		forever begin
			@(negedge clk_24);
			if (check_req && !check_ack) begin
				if (check_kind == kind_audio) begin
					waited = 0;
					while (waited < audio_settle) begin
						@(negedge clk_24);
						waited++;
					end
					ones = 0;
					for (n = 0; n < audio_window; n++) begin
						@(negedge clk_24);
						if (audio_out === 1'b1) ones++;
					end
					actual = 16'(ones);
				end else begin
					stable = 0;
					waited = 0;
					previous = {1'b0, p1_controls, p2_controls, bomb};
					while (stable < stable_needed && waited < settle_limit) begin
						@(negedge clk_24);
						actual = {1'b0, p1_controls, p2_controls, bomb};
						if (actual === previous) stable++;
						else stable = 0;
						previous = actual;
						waited++;
					end
					if (stable < stable_needed) begin
						timeouts++;
						$display("Timeout: control outputs never settled in %s", check_name);
					end
					actual = {1'b0, p1_controls, p2_controls, bomb};
				end
				checks++;
				if (actual !== check_expect) begin
					errors++;
					$display("ERR %s: expected 0x%0h, actual 0x%0h", check_name, check_expect,
						actual);
				end
				check_ack = 1'b1;
			end else if (!check_req) begin
				check_ack = 1'b0;
			end
		end
	end

	// ====================
	// Main sequence
	// ====================
	initial begin : stimulus
		logic [7:0] code;
		logic [7:0] ja;
		logic [7:0] jb;
		logic [7:0] sa;
		logic [7:0] sb;
		int         i;
		int         k;
		void'($urandom(16));
		clk_24 = 1'b0;
		arst_n = 1'b0;
		key_event = '0;
		joy_0 = '0;
		joy_1 = '0;
		rotate = 1'b1;
		snd_a = '0;
		snd_b = '0;
		btn_model = '0;
		joy0_model = '0;
		joy1_model = '0;
		rot_model = 1'b1;
		strobe_state = 1'b0;
		check_req = 1'b0;
		check_kind = kind_controls;
		check_expect = '0;
		check_name = "";
		checks = 0;
		errors = 0;
		timeouts = 0;

		repeat (8) @(posedge clk_24);
		arst_n <= 1'b1;

		// Idle after reset
		run_check("reset controls", kind_controls,
			expected_controls(btn_model, joy0_model, joy1_model, rot_model));
		run_check("reset audio", kind_audio, expected_ones(8'd0, 8'd0));

		// Each mapped key pressed then released, normal table
		for (i = 0; i < 10; i++) begin
			send_key(key_codes[4'(i)], 1'b1);
			run_check($sformatf("key %02h press", key_codes[4'(i)]), kind_controls,
				expected_controls(btn_model, joy0_model, joy1_model, rot_model));
			send_key(key_codes[4'(i)], 1'b0);
			run_check($sformatf("key %02h release", key_codes[4'(i)]), kind_controls,
				expected_controls(btn_model, joy0_model, joy1_model, rot_model));
		end
		for (i = 0; i < 4; i++) begin
			code = 8'($urandom);
			while (is_mapped(code)) begin
				code = 8'($urandom);
			end
			send_key(code, 1'b1);
			run_check($sformatf("unmapped %02h", code), kind_controls,
				expected_controls(btn_model, joy0_model, joy1_model, rot_model));
		end

		// Joysticks alone
		for (i = 0; i < 20; i++) begin
			drive_levels(8'($urandom), 8'($urandom), 1'b1);
			run_check("joysticks", kind_controls,
				expected_controls(btn_model, joy0_model, joy1_model, rot_model));
		end

		// Same states under both direction tables
		for (i = 0; i < 8; i++) begin
			for (k = 0; k < 10; k++) begin
				send_key(key_codes[4'(k)], 1'($urandom));
			end
			ja = 8'($urandom) & 8'($urandom);  // Sparse so keys still matter
			jb = 8'($urandom) & 8'($urandom);
			drive_levels(ja, jb, 1'b0);
			run_check("rotate low", kind_controls,
				expected_controls(btn_model, joy0_model, joy1_model, rot_model));
			drive_levels(ja, jb, 1'b1);
			run_check("rotate high", kind_controls,
				expected_controls(btn_model, joy0_model, joy1_model, rot_model));
		end

		// Pulse density of the sound path
		for (i = 0; i < 6; i++) begin
			sa = 8'($urandom);
			sb = 8'($urandom);
			drive_sound(sa, sb);
			run_check($sformatf("audio %0d %0d", sa, sb), kind_audio, expected_ones(sa, sb));
		end
		drive_sound(8'hFF, 8'hFF);
		run_check("audio full scale", kind_audio, expected_ones(8'hFF, 8'hFF));

		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* verification/cabinet_io_chk.sv */
//====================
// Concurrent checks on the cabinet I/O outputs and the third button
// Bound into every cabinet_io_top instance
//====================

`timescale 1ns/1ps

module cabinet_io_chk import cabinet_pkg::*; (
	input logic                 clk_24,
	input logic                 arst_n,
	input key_event_t           key_event,
	input logic                 btn_fire3,
	input logic [ctl_width-1:0] p1_controls,
	input logic [ctl_width-1:0] p2_controls,
	input logic                 bomb,
	input logic                 audio_out
);

	// Everything cleared while reset is held
	outputs_zero_in_reset: assert property (@(posedge clk_24)
		!arst_n |-> (p1_controls == '0 && p2_controls == '0 && !bomb && !audio_out))
		else $error("outputs not zero during reset");

	// Player 2 has no coin bit
	p2_coin_zero: assert property (@(posedge clk_24) p2_controls[6] == 1'b0)
		else $error("p2_controls bit 6 is set");

	// Directions and fire are shared by both players
	shared_bits_equal: assert property (@(posedge clk_24)
		p1_controls[4:0] == p2_controls[4:0])
		else $error("p1 and p2 direction or fire bits differ");

	// Third button takes the pressed flag of its own key events
	fire3_follows_key: assert property (@(posedge clk_24) disable iff (!arst_n)
		(key_event.strobe != $past(key_event.strobe) && key_event.code == key_fire3)
		|-> ##3 (btn_fire3 == $past(key_event.pressed, 3)))
		else $error("btn_fire3 does not follow its key events");

	audio_known: assert property (@(posedge clk_24) disable iff (!arst_n)
		!$isunknown(audio_out))
		else $error("audio_out is unknown after reset");

endmodule

bind cabinet_io_top cabinet_io_chk u_chk (
	.clk_24      (clk_24),
	.arst_n      (arst_n),
	.key_event   (key_event),
	.btn_fire3   (btn_fire3),
	.p1_controls (p1_controls),
	.p2_controls (p2_controls),
	.bomb        (bomb),
	.audio_out   (audio_out)
);

/* source/cabinet_io_top.sv */
//====================
// Cabinet control and sound path
// key_event, joysticks and rotate are asynchronous host inputs
// snd_a and snd_b must already be synchronous to clk_24
// Joystick and rotate reach the outputs in 3 cycles, key events in 4
//====================

`timescale 1ns/1ps

module cabinet_io_top import cabinet_pkg::*; (
	input  logic                 clk_24,
	input  logic                 arst_n,
	input  key_event_t           key_event,
	input  joy_t                 joy_0,
	input  joy_t                 joy_1,
	input  logic                 rotate,
	input  logic [snd_width-1:0] snd_a,
	input  logic [snd_width-1:0] snd_b,
	output logic [ctl_width-1:0] p1_controls,
	output logic [ctl_width-1:0] p2_controls,
	output logic                 bomb,
	output logic                 audio_out
);

	key_event_t   key_event_sync;
	host_levels_t levels_sync;  // Joystick pair plus rotate

	logic btn_up, btn_down, btn_left, btn_right;
	logic btn_coin, btn_start1, btn_start2;
	logic btn_fire1, btn_fire2, btn_fire3;

	// ====================
	// Synchronizers
	// ====================
	input_sync #(.payload_t(key_event_t)) u_key_sync (
		.clk_24 (clk_24),
		.arst_n (arst_n),
		.d      (key_event),
		.q      (key_event_sync)
	);

	input_sync #(.payload_t(host_levels_t)) u_levels_sync (
		.clk_24 (clk_24),
		.arst_n (arst_n),
		.d      ({rotate, joy_1, joy_0}),
		.q      (levels_sync)
	);

	key_decoder u_key_decoder (
		.clk_24     (clk_24),
		.arst_n     (arst_n),
		.key_event  (key_event_sync),
		.btn_up     (btn_up),
		.btn_down   (btn_down),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.btn_coin   (btn_coin),
		.btn_start1 (btn_start1),
		.btn_start2 (btn_start2),
		.btn_fire1  (btn_fire1),
		.btn_fire2  (btn_fire2),
		.btn_fire3  (btn_fire3)
	);

	control_mapper u_control_mapper (
		.clk_24      (clk_24),
		.arst_n      (arst_n),
		.rotate      (levels_sync.rotate),
		.btn_up      (btn_up),
		.btn_down    (btn_down),
		.btn_left    (btn_left),
		.btn_right   (btn_right),
		.btn_coin    (btn_coin),
		.btn_start1  (btn_start1),
		.btn_start2  (btn_start2),
		.btn_fire1   (btn_fire1),
		.btn_fire2   (btn_fire2),
		.btn_fire3   (btn_fire3),
		.joy_0       (levels_sync.joy_0),
		.joy_1       (levels_sync.joy_1),
		.p1_controls (p1_controls),
		.p2_controls (p2_controls),
		.bomb        (bomb)
	);

	audio_dac u_audio_dac (
		.clk_24    (clk_24),
		.arst_n    (arst_n),
		.snd_a     (snd_a),
		.snd_b     (snd_b),
		.audio_out (audio_out)
	);

endmodule

/* source/audio_dac.sv */
//====================
// Two-channel mixer and first-order sigma-delta DAC
// Inputs must already be synchronous to clk_24
// Output density is mix / 2048; needs an external low-pass filter
//====================

`timescale 1ns/1ps

module audio_dac import cabinet_pkg::*; (
	input  logic                 clk_24,
	input  logic                 arst_n,
	input  logic [snd_width-1:0] snd_a,
	input  logic [snd_width-1:0] snd_b,
	output logic                 audio_out
);

	logic [mix_width-1:0] mix_next;
	logic [mix_width-1:0] mix_q;   // Registered weighted mix
	logic [mix_width-1:0] acc;     // Modulator state
	logic [mix_width:0]   acc_sum; // Carry in the top bit

	// ====================
	// Mixer
	// ====================
	assign mix_next = (mix_width'(snd_b) << snd_b_shift) + mix_width'(snd_a);

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			mix_q <= '0;
		end else begin
			mix_q <= mix_next;
		end
	end

	// ====================
	// Modulator
	// ====================
	assign acc_sum = {1'b0, acc} + {1'b0, mix_q};

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= acc_sum[mix_width-1:0];  // Wraps modulo 2^11
			audio_out <= acc_sum[mix_width];      // One pulse per wrap
		end
	end

endmodule

/* source/control_mapper.sv */
//====================
// Player control words from keys and both joysticks
// rotate high selects the normal table, low the quarter-turned one
// Both players share directions and fire; btn_fire3 is not mapped
//====================

`timescale 1ns/1ps

module control_mapper import cabinet_pkg::*; (
	input  logic                 clk_24,
	input  logic                 arst_n,
	input  logic                 rotate,
	input  logic                 btn_up,
	input  logic                 btn_down,
	input  logic                 btn_left,
	input  logic                 btn_right,
	input  logic                 btn_coin,
	input  logic                 btn_start1,
	input  logic                 btn_start2,
	input  logic                 btn_fire1,
	input  logic                 btn_fire2,
	input  logic                 btn_fire3,  // Left for cores with a third button
	input  joy_t                 joy_0,
	input  joy_t                 joy_1,
	output logic [ctl_width-1:0] p1_controls,
	output logic [ctl_width-1:0] p2_controls,
	output logic                 bomb
);

	// Merged sources before rotation
	logic any_up, any_down, any_left, any_right;
	logic m_up, m_down, m_left, m_right;
	logic m_fire, m_bomb;

	assign any_up    = btn_up    | joy_0.up    | joy_1.up;
	assign any_down  = btn_down  | joy_0.down  | joy_1.down;
	assign any_left  = btn_left  | joy_0.left  | joy_1.left;
	assign any_right = btn_right | joy_0.right | joy_1.right;

	// Quarter turn when rotate is low
	assign m_up    = rotate ? any_up    : any_right;
	assign m_down  = rotate ? any_down  : any_left;
	assign m_left  = rotate ? any_left  : any_up;
	assign m_right = rotate ? any_right : any_down;

	assign m_fire = btn_fire1 | joy_0.fire1 | joy_1.fire1;
	assign m_bomb = btn_fire2 | joy_0.fire2 | joy_1.fire2;

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			p1_controls <= '0;
			p2_controls <= '0;
			bomb        <= 1'b0;
		end else begin
			p1_controls <= {btn_coin, btn_start1, m_fire, m_up, m_down, m_left, m_right};
			p2_controls <= {1'b0, btn_start2, m_fire, m_up, m_down, m_left, m_right};
			bomb        <= m_bomb;
		end
	end

endmodule

/* source/key_decoder.sv */
//====================
// Keyboard event decoder with held button states
// Expects a synchronized event; a strobe of 1 right after reset
// counts as a new event
// Unmapped codes and the extended flag are ignored
//====================

`timescale 1ns/1ps

module key_decoder import cabinet_pkg::*; (
	input  logic       clk_24,
	input  logic       arst_n,
	input  key_event_t key_event,
	output logic       btn_up,
	output logic       btn_down,
	output logic       btn_left,
	output logic       btn_right,
	output logic       btn_coin,
	output logic       btn_start1,
	output logic       btn_start2,
	output logic       btn_fire1,
	output logic       btn_fire2,
	output logic       btn_fire3
);

	logic strobe_prev;  // Strobe value one cycle earlier
	logic new_event;

	assign new_event = key_event.strobe != strobe_prev;

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			strobe_prev <= 1'b0;
		end else begin
			strobe_prev <= key_event.strobe;
		end
	end

	// ====================
	// Held buttons
	// ====================
	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
			btn_fire3  <= 1'b0;
		end else if (new_event) begin
			case (key_event.code)
				key_up:     btn_up     <= key_event.pressed;
				key_down:   btn_down   <= key_event.pressed;
				key_left:   btn_left   <= key_event.pressed;
				key_right:  btn_right  <= key_event.pressed;
				key_coin:   btn_coin   <= key_event.pressed;
				key_start1: btn_start1 <= key_event.pressed;
				key_start2: btn_start2 <= key_event.pressed;
				key_fire1:  btn_fire1  <= key_event.pressed;
				key_fire2:  btn_fire2  <= key_event.pressed;
				key_fire3:  btn_fire3  <= key_event.pressed;
				default: ;  // Not a cabinet key
			endcase
		end
	end

endmodule

/* source/input_sync.sv */
//====================
// Two-flop synchronizer for host-side levels
// Each bit is synchronized on its own; multi-bit payloads may be
// sampled torn for one cycle while they change
//====================

`timescale 1ns/1ps

module input_sync #(
	parameter type payload_t = logic
) (
	input  logic     clk_24,
	input  logic     arst_n,
	input  payload_t d,
	output payload_t q
);

	payload_t stage_1;  // First stage, may be metastable

	always_ff @(posedge clk_24 or negedge arst_n) begin
		if (!arst_n) begin
			stage_1 <= '0;
			q       <= '0;
		end else begin
			stage_1 <= d;
			q       <= stage_1;
		end
	end

endmodule

/* source/cabinet_pkg.sv */
//====================
// Shared widths, key codes and payload types for the cabinet I/O path
// Scan codes are PS/2 set 2 values; the extended flag is not decoded
// Mix and accumulator widths hold snd_b * 4 + snd_a without overflow
//====================

package cabinet_pkg;

	// ====================
	// Control word
	// ====================
	localparam int unsigned ctl_width = 7;  // coin, start, fire, up, down, left, right

	// ====================
	// Key codes
	// ====================
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // ESC
	localparam logic [7:0] key_start1 = 8'h05; // F1
	localparam logic [7:0] key_start2 = 8'h06; // F2
	localparam logic [7:0] key_fire1  = 8'h29; // Space
	localparam logic [7:0] key_fire2  = 8'h11; // Alt
	localparam logic [7:0] key_fire3  = 8'h14; // Ctrl

	// Keyboard event from the host, strobe toggles once per event
	typedef struct packed {
		logic       strobe;    // bit 10
		logic       pressed;   // bit 9
		logic       extended;  // bit 8
		logic [7:0] code;
	} key_event_t;

	// One joystick, active high
	typedef struct packed {
		logic [1:0] unused;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Host levels crossing into clk_24 together
	typedef struct packed {
		logic rotate;
		joy_t joy_1;
		joy_t joy_0;
	} host_levels_t;

	// ====================
	// Sound
	// ====================
	localparam int unsigned snd_width = 8;
	localparam int unsigned mix_width = 11;
	localparam int unsigned snd_b_shift = 2;  // Channel B weighted by 4

endpackage
